// File: vlog.f
+incdir+.
store_buffer_pkg.sv
spec_store_queue.sv
commit_store_queue.sv
page_offset_checker.sv
store_buffer.sv
store_buffer_sva.sv
tb_store_buffer.sv

// File: run.sh
#!/bin/sh
# build and run the store buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_store_buffer -Mdir obj_dir

# the simulation may stop on an assertion, the log decides the result
./obj_dir/Vtb_store_buffer > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
exit 1

// File: tb_store_buffer.sv
`timescale 1ns/10ps
`include "store_buffer_consts.svh"

module tb_store_buffer
    import store_buffer_pkg::*;
();

    localparam int NUM_CYCLES     = 2000;
    // every commit-queue entry gets a drain allowance once stimulus stops
    localparam int TIMEOUT_CYCLES = 2 * NUM_CYCLES + 10 * `SB_DEPTH_COMMIT;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    flush_i;
    logic                    commit_i;
    logic                    load_probe_i;
    logic [`SB_OFFSET_W-1:0] load_offset_i;
    sb_entry_t               store_i;
    sb_mem_rsp_t             mem_rsp_i;
    logic                    ready_o;
    logic                    commit_ready_o;
    logic                    no_st_pending_o;
    logic                    store_buffer_empty_o;
    logic                    page_offset_matches_o;
    sb_mem_req_t             mem_req_o;

    // reference model, one queue per DUT queue, oldest store at index 0
    sb_entry_t spec_q [$];
    sb_entry_t commit_q [$];

    integer seed = 32'hafad_d3a0;
    int     errors;
    int     checks;
    int     committed;
    int     retired;
    int     cycles;

    store_buffer DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // random helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] next_word();
        next_word = $random(seed);
    endfunction

    function automatic int unsigned next_rand(input int unsigned n);
        next_rand = next_word() % n;
    endfunction

    // a handful of doubleword offsets so that loads and stores collide often
    function automatic logic [`SB_OFFSET_W-1:0] random_offset();
        logic [`SB_OFFSET_W-1:0] off;
        case (next_rand(4))
            0: off = 12'h000;
            1: off = 12'h008;
            2: off = 12'h3f8;
            default: off = 12'hff8;
        endcase
        // bits below the compare boundary are free to differ
        off[`SB_CMP_LSB-1:0] = 3'(next_rand(8));
        return off;
    endfunction

    function automatic sb_paddr_u random_address();
        logic [`SB_PADDR_W-1:0] a;
        a = {18'h2_0000, 2'(next_rand(4)), random_offset()};
        return a;
    endfunction

    // ----------------------------------------------------------
    // expected values
    // ----------------------------------------------------------
    function automatic sb_mem_req_t expected_req(input sb_entry_t e, input logic pending);
        sb_mem_req_t            req;
        logic [`SB_PADDR_W-1:0] a;
        a                 = e.address;
        req.data_req      = pending;
        req.address_tag   = a[`SB_PADDR_W-1:`SB_INDEX_W];
        req.address_index = a[`SB_INDEX_W-1:0];
        req.data_wdata    = e.data;
        req.data_be       = e.be;
        req.data_size     = e.size;
        return req;
    endfunction

    function automatic logic offset_hit(input sb_paddr_u addr);
        logic [`SB_PADDR_W-1:0] a;
        a = addr;
        return a[`SB_OFFSET_W-1:`SB_CMP_LSB] == load_offset_i[`SB_OFFSET_W-1:`SB_CMP_LSB];
    endfunction

    function automatic logic expected_match();
        logic hit;
        hit = load_probe_i && offset_hit(store_i.address);
        foreach (spec_q[i]) begin
            hit |= offset_hit(spec_q[i].address);
        end
        foreach (commit_q[i]) begin
            hit |= offset_hit(commit_q[i].address);
        end
        return hit;
    endfunction

    // ----------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------
    // without data_req the remaining request fields carry no meaning
    task automatic compare_req(input sb_mem_req_t exp, input sb_mem_req_t act, input string what);
        checks++;
        if ((act.data_req !== exp.data_req) || (exp.data_req && (act !== exp))) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, what, exp, act);
        end
    endtask

    task automatic compare_bit(input logic exp, input logic act, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %b got %b", $time, what, exp, act);
        end
    endtask

    // ----------------------------------------------------------
    // model and stimulus, both run right at the rising edge
    // ----------------------------------------------------------
    // inputs read here are the ones the DUT samples at this edge
    task automatic update_model();
        logic retire;
        retire = (commit_q.size() != 0) && mem_rsp_i.data_gnt;
        if (flush_i) begin
            spec_q.delete();
        end else begin
            if (commit_i) begin
                commit_q.push_back(spec_q.pop_front());
                committed++;
            end
            if (store_i.valid) begin
                spec_q.push_back(store_i);
            end
        end
        if (retire) begin
            void'(commit_q.pop_front());
        end
    endtask

    // in drain mode nothing new enters and every request is granted
    task automatic drive_stimulus(input logic drain);
        logic      do_flush;
        logic      do_commit;
        logic      do_push;
        sb_entry_t st;
        do_flush  = !drain && (next_rand(16) == 0);
        do_commit = !do_flush && (spec_q.size() != 0) &&
                    (commit_q.size() < `SB_DEPTH_COMMIT) && (drain || (next_rand(2) == 0));
        do_push   = !drain && ((spec_q.size() < `SB_DEPTH_SPEC - 1) || do_commit) &&
                    (next_rand(3) != 0);
        st.address = random_address();
        st.data    = {next_word(), next_word()};
        st.be      = 8'(next_word());
        st.size    = 2'(next_word());
        st.valid   = do_push;
        store_i            <= st;
        flush_i            <= do_flush;
        commit_i           <= do_commit;
        mem_rsp_i.data_gnt <= drain || (next_rand(3) == 0);
        load_offset_i      <= random_offset();
        load_probe_i       <= (next_rand(2) == 0);
    endtask

    task automatic check_outputs();
        sb_entry_t head;
        head = '0;
        if (commit_q.size() != 0) begin
            head = commit_q[0];
        end
        compare_req(expected_req(head, commit_q.size() != 0), mem_req_o, "write request");
        // a request seen together with a grant here is taken by the cache at the next edge
        if (mem_req_o.data_req && mem_rsp_i.data_gnt) begin
            retired++;
        end
        compare_bit((spec_q.size() < `SB_DEPTH_SPEC - 1) || commit_i, ready_o, "ready_o");
        compare_bit(commit_q.size() < `SB_DEPTH_COMMIT, commit_ready_o, "commit_ready_o");
        compare_bit(commit_q.size() == 0, no_st_pending_o, "no_st_pending_o");
        compare_bit((spec_q.size() == 0) && (commit_q.size() == 0), store_buffer_empty_o,
                    "store_buffer_empty_o");
        compare_bit(expected_match(), page_offset_matches_o, "page_offset_matches_o");
    endtask

    task automatic run_cycle(input logic drain);
        @(posedge clk_i);
        update_model();
        drive_stimulus(drain);
        // outputs are settled half a period later
        @(negedge clk_i);
        check_outputs();
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        errors        = 0;
        checks        = 0;
        committed     = 0;
        retired       = 0;
        rst_ni        = 1'b0;
        flush_i       = 1'b0;
        commit_i      = 1'b0;
        load_probe_i  = 1'b0;
        load_offset_i = '0;
        store_i       = '0;
        mem_rsp_i     = '0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        compare_req('0, mem_req_o, "write request after reset");
        compare_bit(1'b1, ready_o, "ready_o after reset");
        compare_bit(1'b1, commit_ready_o, "commit_ready_o after reset");
        compare_bit(1'b1, no_st_pending_o, "no_st_pending_o after reset");
        compare_bit(1'b1, store_buffer_empty_o, "store_buffer_empty_o after reset");
        compare_bit(1'b0, page_offset_matches_o, "page_offset_matches_o after reset");
        for (int c = 0; c < NUM_CYCLES; c++) begin
            run_cycle(1'b0);
        end
        // leftover speculative stores are committed and everything is written out
        while ((spec_q.size() != 0) || (commit_q.size() != 0)) begin
            run_cycle(1'b1);
        end
        if (retired != committed) begin
            errors++;
            $display("%0d stores were committed but %0d writes were retired", committed, retired);
        end
        $display("checks %0d, commits %0d, writes %0d, errors %0d",
                 checks, committed, retired, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: store_buffer_sva.sv
`timescale 1ns/10ps

module store_buffer_sva
    import store_buffer_pkg::*;
(
    input logic        clk_i,
    input logic        rst_ni,
    input logic        flush_i,
    input logic        commit_i,
    input logic        ready_o,
    input sb_entry_t   store_i,
    input sb_mem_req_t mem_req_o,
    input sb_mem_rsp_t mem_rsp_i
);

    // a store cannot be committed and discarded in the same cycle
    commit_flush_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(commit_i && flush_i))
        else $error("commit and flush are both high");

    // the speculative queue keeps one slot spare, a push needs ready_o
    push_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        store_i.valid |-> ready_o)
        else $error("store pushed while ready_o is low");

    // an ungranted request keeps its fields until the cache takes it
    req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o.data_req && !mem_rsp_i.data_gnt) |=>
        (mem_req_o.data_req && $stable(mem_req_o)))
        else $error("write request changed before its grant");

endmodule

bind store_buffer store_buffer_sva u_sva (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .commit_i  (commit_i),
    .ready_o   (ready_o),
    .store_i   (store_i),
    .mem_req_o (mem_req_o),
    .mem_rsp_i (mem_rsp_i)
);

// File: store_buffer.sv
`timescale 1ns/10ps
`include "store_buffer_consts.svh"

module store_buffer
    import store_buffer_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  sb_entry_t               store_i,
    input  logic                    commit_i,
    input  logic [`SB_OFFSET_W-1:0] load_offset_i,
    input  logic                    load_probe_i,
    input  sb_mem_rsp_t             mem_rsp_i,
    output logic                    ready_o,
    output logic                    commit_ready_o,
    output logic                    no_st_pending_o,
    output logic                    store_buffer_empty_o,
    output logic                    page_offset_matches_o,
    output sb_mem_req_t             mem_req_o
);

    sb_entry_t                        spec_head;
    sb_entry_t                        spec_entries [`SB_DEPTH_SPEC-1:0];
    sb_entry_t                        commit_entries [`SB_DEPTH_COMMIT-1:0];
    logic [$clog2(`SB_DEPTH_SPEC):0]   spec_count;
    logic [$clog2(`SB_DEPTH_COMMIT):0] commit_count;

    // ----------------------------------------------------------
    // queues
    // ----------------------------------------------------------
    // a commit pops the speculative head and pushes it into the commit queue on one edge
    spec_store_queue u_spec_queue (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .store_i   (store_i),
        .pop_i     (commit_i),
        .flush_i   (flush_i),
        .head_o    (spec_head),
        .entries_o (spec_entries),
        .count_o   (spec_count)
    );

    commit_store_queue u_commit_queue (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .push_i    (commit_i),
        .entry_i   (spec_head),
        .mem_rsp_i (mem_rsp_i),
        .mem_req_o (mem_req_o),
        .entries_o (commit_entries),
        .count_o   (commit_count)
    );

    // the incoming store address is checked as well when the load path asks for it
    page_offset_checker u_checker (
        .load_offset_i    (load_offset_i),
        .spec_entries_i   (spec_entries),
        .commit_entries_i (commit_entries),
        .probe_addr_i     (store_i.address),
        .probe_valid_i    (load_probe_i),
        .match_o          (page_offset_matches_o)
    );

    // ----------------------------------------------------------
    // status
    // ----------------------------------------------------------
    // one slot is kept spare unless a commit frees the head this cycle
    assign ready_o              = (spec_count < (`SB_DEPTH_SPEC - 1)) || commit_i;
    assign commit_ready_o       = (commit_count < `SB_DEPTH_COMMIT);
    // nothing is pending towards memory once the commit queue is empty
    assign no_st_pending_o      = (commit_count == '0);
    assign store_buffer_empty_o = (spec_count == '0) && no_st_pending_o;

endmodule

// File: page_offset_checker.sv
`timescale 1ns/10ps
`include "store_buffer_consts.svh"

module page_offset_checker
    import store_buffer_pkg::*;
(
    input  logic [`SB_OFFSET_W-1:0] load_offset_i,
    input  sb_entry_t               spec_entries_i [`SB_DEPTH_SPEC-1:0],
    input  sb_entry_t               commit_entries_i [`SB_DEPTH_COMMIT-1:0],
    input  sb_paddr_u               probe_addr_i,
    input  logic                    probe_valid_i,
    output logic                    match_o
);

    // only the doubleword part of the offset takes part in the compare
    logic [`SB_OFFSET_W-1:`SB_CMP_LSB] load_dw;

    assign load_dw = load_offset_i[`SB_OFFSET_W-1:`SB_CMP_LSB];

    // ----------------------------------------------------------
    // offset compare
    // ----------------------------------------------------------
    // a match tells the load path to wait until the buffer has drained
    always_comb begin
        match_o = 1'b0;
        // committed stores are already on their way to memory
        for (int i = 0; i < `SB_DEPTH_COMMIT; i++) begin
            if (commit_entries_i[i].valid &&
                (commit_entries_i[i].address.page.offset[`SB_OFFSET_W-1:`SB_CMP_LSB] == load_dw)) begin
                match_o = 1'b1;
            end
        end
        // speculative stores may still be flushed but are counted as hazards too
        for (int i = 0; i < `SB_DEPTH_SPEC; i++) begin
            if (spec_entries_i[i].valid &&
                (spec_entries_i[i].address.page.offset[`SB_OFFSET_W-1:`SB_CMP_LSB] == load_dw)) begin
                match_o = 1'b1;
            end
        end
        // the store arriving this cycle is not in either queue yet
        if (probe_valid_i &&
            (probe_addr_i.page.offset[`SB_OFFSET_W-1:`SB_CMP_LSB] == load_dw)) begin
            match_o = 1'b1;
        end
    end

endmodule

// File: commit_store_queue.sv
`timescale 1ns/10ps
`include "store_buffer_consts.svh"

module commit_store_queue
    import store_buffer_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             push_i,
    input  sb_entry_t                        entry_i,
    input  sb_mem_rsp_t                      mem_rsp_i,
    output sb_mem_req_t                      mem_req_o,
    output sb_entry_t                        entries_o [`SB_DEPTH_COMMIT-1:0],
    output logic [$clog2(`SB_DEPTH_COMMIT):0] count_o
);

    localparam int unsigned ptr_w = $clog2(`SB_DEPTH_COMMIT);

    sb_entry_t                   mem_q [`SB_DEPTH_COMMIT-1:0];
    logic [`SB_DEPTH_COMMIT-1:0] valid_d, valid_q;
    logic [ptr_w-1:0]            rd_ptr_d, rd_ptr_q;
    logic [ptr_w-1:0]            wr_ptr_d, wr_ptr_q;
    logic [ptr_w:0]              cnt_d, cnt_q;
    logic                        retire;
    sb_entry_t                   head;

    // the write at the head completes when the cache grants an active request
    assign head   = mem_q[rd_ptr_q];
    assign retire = valid_q[rd_ptr_q] && mem_rsp_i.data_gnt;

    // ----------------------------------------------------------
    // next state
    // ----------------------------------------------------------
    always_comb begin
        valid_d  = valid_q;
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q + {{ptr_w{1'b0}}, push_i} - {{ptr_w{1'b0}}, retire};
        if (retire) begin
            valid_d[rd_ptr_q] = 1'b0;
            rd_ptr_d          = rd_ptr_q + 1'b1;
        end
        // a push never lands on the head slot while it is still valid, the queue is not full
        if (push_i) begin
            valid_d[wr_ptr_q] = 1'b1;
            wr_ptr_d          = wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            valid_q  <= valid_d;
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    // ----------------------------------------------------------
    // memory port
    // ----------------------------------------------------------
    // the head stays put until granted, so the request fields are stable by construction
    assign mem_req_o.data_req      = valid_q[rd_ptr_q];
    assign mem_req_o.address_tag   = head.address.cache.tag;
    assign mem_req_o.address_index = head.address.cache.index;
    assign mem_req_o.data_wdata    = head.data;
    assign mem_req_o.data_be       = head.be;
    assign mem_req_o.data_size     = head.size;

    always_comb begin
        for (int i = 0; i < `SB_DEPTH_COMMIT; i++) begin
            entries_o[i]       = mem_q[i];
            entries_o[i].valid = valid_q[i];
        end
    end

    assign count_o = cnt_q;

endmodule

// File: spec_store_queue.sv
`timescale 1ns/10ps
`include "store_buffer_consts.svh"

module spec_store_queue
    import store_buffer_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  sb_entry_t                      store_i,
    input  logic                           pop_i,
    input  logic                           flush_i,
    output sb_entry_t                      head_o,
    output sb_entry_t                      entries_o [`SB_DEPTH_SPEC-1:0],
    output logic [$clog2(`SB_DEPTH_SPEC):0] count_o
);

    localparam int unsigned ptr_w = $clog2(`SB_DEPTH_SPEC);

    // payload storage, the valid flags live in their own vector
    sb_entry_t                 mem_q [`SB_DEPTH_SPEC-1:0];
    logic [`SB_DEPTH_SPEC-1:0] valid_d, valid_q;
    logic [ptr_w-1:0]          rd_ptr_d, rd_ptr_q;
    logic [ptr_w-1:0]          wr_ptr_d, wr_ptr_q;
    logic [ptr_w:0]            cnt_d, cnt_q;
    logic                      push;

    // a valid store on the input is a push request
    assign push = store_i.valid;

    // ----------------------------------------------------------
    // next state
    // ----------------------------------------------------------
    always_comb begin
        valid_d  = valid_q;
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q + {{ptr_w{1'b0}}, push} - {{ptr_w{1'b0}}, pop_i};
        if (push) begin
            valid_d[wr_ptr_q] = 1'b1;
            wr_ptr_d          = wr_ptr_q + 1'b1;
        end
        // the head leaves towards the commit queue on the same edge
        if (pop_i) begin
            valid_d[rd_ptr_q] = 1'b0;
            rd_ptr_d          = rd_ptr_q + 1'b1;
        end
        // a flush drops everything that was not committed, including a store pushed now
        if (flush_i) begin
            valid_d  = '0;
            wr_ptr_d = rd_ptr_q;
            cnt_d    = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            valid_q  <= valid_d;
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= store_i;
        end
    end

    // ----------------------------------------------------------
    // outputs
    // ----------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `SB_DEPTH_SPEC; i++) begin
            entries_o[i]       = mem_q[i];
            entries_o[i].valid = valid_q[i];
        end
        // the oldest uncommitted store, invalid when the queue is empty
        head_o       = mem_q[rd_ptr_q];
        head_o.valid = valid_q[rd_ptr_q];
    end

    assign count_o = cnt_q;

endmodule

// File: store_buffer_pkg.sv
`include "store_buffer_consts.svh"

package store_buffer_pkg;

    // cache view of an address, used when the write goes out to memory
    typedef struct packed {
        logic [`SB_PADDR_W-`SB_INDEX_W-1:0] tag;
        logic [`SB_INDEX_W-1:0]             index;
    } sb_cache_addr_t;

    // page view of the same address, the offset feeds the load hazard check
    typedef struct packed {
        logic [`SB_PADDR_W-`SB_OFFSET_W-1:0] pnum;
        logic [`SB_OFFSET_W-1:0]             offset;
    } sb_page_addr_t;

    // one address word, decoded either way depending on the consumer
    typedef union packed {
        sb_cache_addr_t cache;
        sb_page_addr_t  page;
    } sb_paddr_u;

    // a buffered store, valid marks an occupied slot (or a push on the input side)
    typedef struct packed {
        sb_paddr_u             address;
        logic [`SB_DATA_W-1:0] data;
        logic [`SB_BE_W-1:0]   be;
        logic [`SB_SIZE_W-1:0] size;
        logic                  valid;
    } sb_entry_t;

    // write request towards the data cache, held until granted
    typedef struct packed {
        logic                               data_req;
        logic [`SB_PADDR_W-`SB_INDEX_W-1:0] address_tag;
        logic [`SB_INDEX_W-1:0]             address_index;
        logic [`SB_DATA_W-1:0]              data_wdata;
        logic [`SB_BE_W-1:0]                data_be;
        logic [`SB_SIZE_W-1:0]              data_size;
    } sb_mem_req_t;

    // the grant completes the transfer, there is no separate write response
    typedef struct packed {
        logic data_gnt;
    } sb_mem_rsp_t;

endpackage

// File: store_buffer_consts.svh
`ifndef STORE_BUFFER_CONSTS_SVH
`define STORE_BUFFER_CONSTS_SVH

// physical address width as seen by the data cache
`define SB_PADDR_W 32

// store payload, one doubleword with a byte mask and a size code
`define SB_DATA_W 64
`define SB_BE_W 8
`define SB_SIZE_W 2

// the cache splits the address into tag and index, the tag takes the upper bits
`define SB_INDEX_W 12

// page offset is identical in the virtual and the physical address
`define SB_OFFSET_W 12

// loads and stores are compared at doubleword granularity
`define SB_CMP_LSB 3

// both queue depths must be powers of two so the pointers wrap on their own
`define SB_DEPTH_SPEC 4
`define SB_DEPTH_COMMIT 4

`endif
